//--- verif/vtp_testdata.hex
// Header: page table base line, entry count, phase 1 reads, phase 2 reads
// Entries: 4 KB page index, entry. Reads: virtual line, tag, expected physical line
// The last read targets the absent page, so its expected column is unused
0200000 7 8 6
// Page table image, the 2 MB entries have big_page set
00012 8000A5C3
00013 8001F2E0
04A51 80033331
7F0C8 80000421
24605 C005E1AB
75010 C0081234
0BEEF 00012345
// Phase 1, first touch of every page
0000485 001 02970C5
00004BF 002 02970FF
00004D0 003 07CB810
0129461 004 0CCCC61
091814A 005 178014A
1FC3200 006 0010840
1D40433 007 2048433
00004C1 008 07CB801
// Phase 2, every read hits, with new 4 KB pages inside both 2 MB regions
091FFFE 009 1787FFE
1D46880 00A 204E880
00004A0 00B 02970E0
0129440 00C 0CCCC40
1FC323F 00D 001087F
0918000 00E 1780000
// Read to the absent page
02FBBC7 00F 0000000

//--- tb.f
logic/vtp_pkg.sv
logic/vtp_lookup_issue.sv
logic/vtp_tlb.sv
logic/vtp_lookup_merge.sv
logic/vtp_pt_walker.sv
logic/vtp_top.sv
verif/vtp_clock_gen.sv
verif/vtp_tb.sv

//--- Bender.yml
package:
  name: vtp

sources:
  - logic/vtp_pkg.sv
  - logic/vtp_lookup_issue.sv
  - logic/vtp_tlb.sv
  - logic/vtp_lookup_merge.sv
  - logic/vtp_pt_walker.sv
  - logic/vtp_top.sv
  - target: simulation
    files:
      - verif/vtp_clock_gen.sv
      - verif/vtp_tb.sv

//--- verif/vtp_tb.sv
`timescale 1ns/1ps

// Testbench for the translation shim
// Loads a page table image and client reads from the test data file, models the
// memory port with random latency and back-pressure, and scores every result

module vtp_tb;

    localparam vtp_pkg::mdata_t pt_tag = vtp_pkg::mdata_t'(1) << vtp_pkg::pt_tag_bit;
    localparam int max_reads = 32;
    localparam int max_ptes = 32;
    localparam int hold_cycles = 50;

    logic clk;
    logic reset;
    logic afu_req_valid;
    vtp_pkg::mem_req_t afu_req;
    logic afu_almost_full;
    logic afu_rsp_valid;
    vtp_pkg::mem_rsp_t afu_rsp;
    logic mem_req_valid;
    vtp_pkg::mem_req_t mem_req;
    logic mem_almost_full = 1'b0;
    logic mem_rsp_valid = 1'b0;
    vtp_pkg::mem_rsp_t mem_rsp = '0;
    vtp_pkg::pa_line_t pt_base;
    logic pt_error;

    // ========================================
    // Test data and scoreboard
    // ========================================

    logic [31:0] tdata [256];
    int n_ptes;
    int n_phase1;
    int n_phase2;
    int n_reads;
    vtp_pkg::va_page_4k_t pte_page [max_ptes];
    vtp_pkg::mem_data_t pte_value [max_ptes];
    vtp_pkg::va_line_t rd_va [max_reads];
    vtp_pkg::mdata_t rd_tag [max_reads];
    vtp_pkg::pa_line_t rd_pa [max_reads];
    vtp_pkg::mdata_t absent_tag;

    // Indexed by tag, since the shim may reorder reads
    logic pending_req [4096];
    logic pending_rsp [4096];
    vtp_pkg::pa_line_t expected_pa [4096];

    int done_count = 0;
    int cycle = 0;
    int burst_count = 0;
    integer seed = 32'h2d4af630;
    logic loaded = 1'b0;
    logic walks_allowed = 1'b0;
    logic absent_sent = 1'b0;
    logic pt_error_seen = 1'b0;

    // Responses waiting in the memory model with the cycle they may leave
    vtp_pkg::mem_rsp_t rsp_queue [$];
    int due_queue [$];

    vtp_clock_gen u_clock (.clk);

    vtp_top #(.tlb_sets_4k(64), .tlb_sets_2m(16)) u_dut (
        .clk, .reset, .afu_req_valid, .afu_req, .afu_almost_full, .afu_rsp_valid,
        .afu_rsp, .mem_req_valid, .mem_req, .mem_almost_full, .mem_rsp_valid,
        .mem_rsp, .pt_base, .pt_error
    );

    // ========================================
    // Reporting and compare tasks
    // ========================================

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_req(input string name, input vtp_pkg::mem_req_t got,
                             input vtp_pkg::mem_req_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_rsp(input string name, input vtp_pkg::mem_rsp_t got,
                             input vtp_pkg::mem_rsp_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // Entries missing from the image read back as zero, which is not present
    function automatic vtp_pkg::mem_data_t table_entry(input vtp_pkg::va_page_4k_t page);
        vtp_pkg::mem_data_t value;
        value = '0;
        for (int i = 0; i < n_ptes; i++)
            if (pte_page[i] == page)
                value = pte_value[i];
        return value;
    endfunction

    // A page-table read must belong to a client read that is still waiting
    task automatic verify_pt_read(input vtp_pkg::mem_req_t req,
                                  input vtp_pkg::va_page_4k_t page);
        vtp_pkg::mem_req_t exp;
        logic found;
        found = 1'b0;
        if (!walks_allowed)
            report_failure("a page-table read was sent while every page should hit");
        for (int i = 0; i < n_reads; i++)
            if (pending_req[rd_tag[i]] && rd_va[i][25:6] == page)
                found = 1'b1;
        if (!found)
            report_failure("a page-table read went to a page no pending read uses");
        exp.addr = pt_base + vtp_pkg::pa_line_t'(page);
        exp.tag = pt_tag;
        check_req("mem_req", req, exp);
    endtask

    task automatic record_translated(input vtp_pkg::mem_req_t req);
        vtp_pkg::mem_req_t exp;
        if (req.tag == absent_tag)
            report_failure("the read to the absent page reached memory");
        if (!pending_req[req.tag])
            report_failure($sformatf("translated read with tag %h was not expected", req.tag));
        exp.addr = expected_pa[req.tag];
        exp.tag = req.tag;
        check_req("mem_req", req, exp);
        pending_req[req.tag] = 1'b0;
        pending_rsp[req.tag] = 1'b1;
    endtask

    // Page-table reads get the image entry and client reads get their own tag as data
    task automatic accept_request(input vtp_pkg::mem_req_t req);
        vtp_pkg::mem_rsp_t rsp;
        vtp_pkg::va_page_4k_t page;
        rsp.tag = req.tag;
        if (req.tag[vtp_pkg::pt_tag_bit])
        begin
            page = vtp_pkg::va_page_4k_t'(req.addr - pt_base);
            verify_pt_read(req, page);
            rsp.data = table_entry(page);
        end
        else
        begin
            record_translated(req);
            rsp.data = vtp_pkg::mem_data_t'(req.tag);
        end
        rsp_queue.push_back(rsp);
        due_queue.push_back(cycle + 1 + ($random(seed) & 3));
    endtask

    task automatic score_response(input vtp_pkg::mem_rsp_t rsp);
        vtp_pkg::mem_rsp_t exp;
        if (rsp.tag[vtp_pkg::pt_tag_bit])
            report_failure("a page-table response was passed to the client");
        if (!pending_rsp[rsp.tag])
            report_failure($sformatf("response with tag %h has no outstanding read", rsp.tag));
        exp.tag = rsp.tag;
        exp.data = vtp_pkg::mem_data_t'(rsp.tag);
        check_rsp("afu_rsp", rsp, exp);
        pending_rsp[rsp.tag] = 1'b0;
        done_count = done_count + 1;
    endtask

    // One read per cycle while the shim has room, holding off while almost full
    task automatic send_reads(input int first, input int count);
        for (int i = first; i < first + count; i++)
        begin
            @(posedge clk);
            while (afu_almost_full)
            begin
                afu_req_valid <= 1'b0;
                @(posedge clk);
            end
            pending_req[rd_tag[i]] = 1'b1;
            expected_pa[rd_tag[i]] = rd_pa[i];
            afu_req_valid <= 1'b1;
            afu_req.addr <= rd_va[i];
            afu_req.tag <= rd_tag[i];
        end
        @(posedge clk);
        afu_req_valid <= 1'b0;
    endtask

    task automatic wait_responses(input int count);
        while (done_count < count)
            @(posedge clk);
    endtask

    // ========================================
    // Memory model and monitors
    // ========================================

    always @(posedge clk)
    begin : memory_model
        int slot;
        slot = -1;
        if (!reset)
        begin
            mem_rsp_valid <= 1'b0;
            mem_almost_full <= 1'b0;
            burst_count = 0;
        end
        else
        begin
            cycle = cycle + 1;
            // Requests seen while almost full is up count against the 3 allowed
            if (!mem_almost_full)
                burst_count = 0;
            else if (mem_req_valid)
                burst_count = burst_count + 1;
            if (burst_count > 3)
                report_failure("more than 3 requests followed the rise of mem_almost_full");
            if (mem_req_valid)
                accept_request(mem_req);

            // The oldest response whose delay is over leaves first
            for (int i = 0; i < rsp_queue.size(); i++)
                if (slot < 0 && due_queue[i] <= cycle)
                    slot = i;
            if (slot >= 0)
            begin
                mem_rsp_valid <= 1'b1;
                mem_rsp <= rsp_queue[slot];
                rsp_queue.delete(slot);
                due_queue.delete(slot);
            end
            else
            begin
                mem_rsp_valid <= 1'b0;
            end

            if (($random(seed) & 7) == 0)
                mem_almost_full <= !mem_almost_full;
        end
    end

    always @(posedge clk)
    begin
        if (reset && afu_rsp_valid)
            score_response(afu_rsp);
    end

    // pt_error must stay low for present pages and stay high once it rises
    always @(posedge clk)
    begin
        if (reset)
        begin
            if (pt_error_seen)
                expect_flag("pt_error", pt_error, 1'b1);
            else if (!absent_sent)
                expect_flag("pt_error", pt_error, 1'b0);
            else if (pt_error)
                pt_error_seen = 1'b1;
        end
    end

    initial
    begin : watchdog
        wait (loaded);
        repeat (n_reads * 200 + 16 + hold_cycles)
            @(posedge clk);
        report_failure("timeout, the reads did not complete in the allowed time");
    end

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin : stimulus
        int base;
        reset = 1'b0;
        afu_req_valid = 1'b0;
        afu_req = '0;
        pt_base = '0;
        for (int i = 0; i < 4096; i++)
        begin
            pending_req[i] = 1'b0;
            pending_rsp[i] = 1'b0;
            expected_pa[i] = '0;
        end

        $readmemh("verif/vtp_testdata.hex", tdata);
        if ($isunknown(tdata[0]) || $isunknown(tdata[3]))
            report_failure("the test data file could not be read");
        pt_base = vtp_pkg::pa_line_t'(tdata[0]);
        n_ptes = int'(tdata[1]);
        n_phase1 = int'(tdata[2]);
        n_phase2 = int'(tdata[3]);
        n_reads = n_phase1 + n_phase2 + 1;
        for (int i = 0; i < n_ptes; i++)
        begin
            pte_page[i] = vtp_pkg::va_page_4k_t'(tdata[4 + 2 * i]);
            pte_value[i] = tdata[5 + 2 * i];
        end
        base = 4 + 2 * n_ptes;
        for (int i = 0; i < n_reads; i++)
        begin
            rd_va[i] = vtp_pkg::va_line_t'(tdata[base + 3 * i]);
            rd_tag[i] = vtp_pkg::mdata_t'(tdata[base + 3 * i + 1]);
            rd_pa[i] = vtp_pkg::pa_line_t'(tdata[base + 3 * i + 2]);
        end
        // The last read points at the page whose entry is not present
        absent_tag = rd_tag[n_reads - 1];
        loaded = 1'b1;

        repeat (16)
            @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        expect_flag("afu_almost_full", afu_almost_full, 1'b0);
        expect_flag("mem_req_valid", mem_req_valid, 1'b0);
        expect_flag("afu_rsp_valid", afu_rsp_valid, 1'b0);
        expect_flag("pt_error", pt_error, 1'b0);

        // First touch of every page, so each one is walked
        walks_allowed = 1'b1;
        send_reads(0, n_phase1);
        wait_responses(n_phase1);
        repeat (8)
            @(posedge clk);

        // Pages filled above, including other 4 KB pages inside the 2 MB regions
        walks_allowed = 1'b0;
        send_reads(n_phase1, n_phase2);
        wait_responses(n_phase1 + n_phase2);
        repeat (8)
            @(posedge clk);

        // The absent page keeps walking and its read must never leave
        walks_allowed = 1'b1;
        absent_sent = 1'b1;
        send_reads(n_phase1 + n_phase2, 1);
        while (!pt_error)
            @(posedge clk);
        repeat (hold_cycles)
            @(posedge clk);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verif/vtp_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock for the translation shim testbench

module vtp_clock_gen
#(
    parameter int half_period_ns = 10
)
(
    output logic clk
);

    // Starts low so the first rising edge comes half a period in
    initial
    begin
        clk = 1'b0;
        forever
            #(half_period_ns) clk = ~clk;
    end

endmodule

//--- logic/vtp_top.sv
`timescale 1ns/1ps

// Top of the translation shim between a read client and a memory port
// Holds one TLB per page size and gives page-table reads priority on the port

module vtp_top
#(
    parameter int tlb_sets_4k = 64,
    parameter int tlb_sets_2m = 16
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic               afu_req_valid,
    input  vtp_pkg::mem_req_t  afu_req,
    output logic               afu_almost_full,
    output logic               afu_rsp_valid,
    output vtp_pkg::mem_rsp_t  afu_rsp,
    output logic               mem_req_valid,
    output vtp_pkg::mem_req_t  mem_req,
    input  logic               mem_almost_full,
    input  logic               mem_rsp_valid,
    input  vtp_pkg::mem_rsp_t  mem_rsp,
    input  vtp_pkg::pa_line_t  pt_base,
    output logic               pt_error
);

    localparam vtp_pkg::mdata_t pt_tag = vtp_pkg::mdata_t'(1) << vtp_pkg::pt_tag_bit;

    vtp_pkg::tlb_lookup_t lookup;
    vtp_pkg::tlb_answer_t answer [vtp_pkg::page_sizes];
    vtp_pkg::mem_req_t out_req;
    vtp_pkg::mem_req_t replay_req;
    vtp_pkg::mem_req_t port_req;
    vtp_pkg::va_page_4k_t miss_page;
    vtp_pkg::pa_line_t pt_rd_addr;
    vtp_pkg::tlb_fill_t fill;
    logic out_valid;
    logic replay_valid;
    logic miss_valid;
    logic pt_rd_valid;
    logic pt_rd_taken;
    logic pt_rsp_valid;
    logic fill_done;
    logic issue_full;

    // ========================================
    // Translation pipeline
    // ========================================

    // A waiting page-table read stops new lookups so the port drains for it
    assign issue_full = mem_almost_full || pt_rd_valid;

    vtp_lookup_issue #(.skid_depth(8), .replay_depth(4)) u_issue (
        .clk, .reset, .afu_req_valid, .afu_req, .mem_full(issue_full),
        .replay_valid, .replay_req, .fill_done, .afu_almost_full, .lookup
    );

    for (genvar i = 0; i < vtp_pkg::page_sizes; i++)
    begin : g_tlb
        vtp_pkg::tlb_fill_t tlb_fill;

        // Fills go only to the TLB of the entry's page size
        always_comb
        begin
            tlb_fill = fill;
            tlb_fill.en = fill.en && (int'(fill.big_page) == i);
        end

        vtp_tlb #(
            .line_bits(vtp_pkg::page_line_bits[i]),
            .sets(i == 0 ? tlb_sets_4k : tlb_sets_2m)
        ) u_tlb (
            .clk, .reset, .lookup, .fill(tlb_fill), .answer(answer[i])
        );
    end

    vtp_lookup_merge u_merge (
        .clk, .reset, .lookup, .answer, .out_valid, .out_req,
        .replay_valid, .replay_req, .miss_valid, .miss_page
    );

    vtp_pt_walker u_walker (
        .clk, .reset, .pt_base, .miss_valid, .miss_page, .pt_rd_taken,
        .pt_rsp_valid, .pt_rsp_data(mem_rsp.data), .pt_rd_valid, .pt_rd_addr,
        .fill, .fill_done, .pt_error
    );

    // ========================================
    // Memory port and response steering
    // ========================================

    // The walker read takes the first free slot while memory can accept it
    assign pt_rd_taken = pt_rd_valid && !out_valid && !mem_almost_full;
    assign pt_rsp_valid = mem_rsp_valid && mem_rsp.tag[vtp_pkg::pt_tag_bit];

    always_comb
    begin
        port_req = out_req;
        if (!out_valid)
        begin
            port_req.addr = pt_rd_addr;
            port_req.tag = pt_tag;
        end
    end

    always_ff @(posedge clk)
    begin
        mem_req <= port_req;
        afu_rsp <= mem_rsp;
        if (!reset)
        begin
            mem_req_valid <= 1'b0;
            afu_rsp_valid <= 1'b0;
        end
        else
        begin
            mem_req_valid <= out_valid || pt_rd_taken;
            // Page-table responses stay inside the shim
            afu_rsp_valid <= mem_rsp_valid && !mem_rsp.tag[vtp_pkg::pt_tag_bit];
        end
    end

endmodule

//--- logic/vtp_pt_walker.sv
`timescale 1ns/1ps

// Page-table walker for a single-level table with one entry per line
// Reads the entry of one missing page at a time and fills the TLB of its size

module vtp_pt_walker
(
    input  logic                  clk,
    input  logic                  reset,
    input  vtp_pkg::pa_line_t     pt_base,
    input  logic                  miss_valid,
    input  vtp_pkg::va_page_4k_t  miss_page,
    input  logic                  pt_rd_taken,
    input  logic                  pt_rsp_valid,
    input  vtp_pkg::mem_data_t    pt_rsp_data,
    output logic                  pt_rd_valid,
    output vtp_pkg::pa_line_t     pt_rd_addr,
    output vtp_pkg::tlb_fill_t    fill,
    output logic                  fill_done,
    output logic                  pt_error
);

    vtp_pkg::walk_state_t state;
    vtp_pkg::va_page_4k_t page_q;
    vtp_pkg::pte_t pte_q;

    always_ff @(posedge clk)
    begin
        if (state == vtp_pkg::idle)
            page_q <= miss_page;
        // The entry sits in word 0 of the returned line
        if (state == vtp_pkg::wait_rsp)
            pte_q <= vtp_pkg::pte_t'(pt_rsp_data);

        if (!reset)
        begin
            state <= vtp_pkg::idle;
            pt_error <= 1'b0;
        end
        else
        begin
            case (state)
                vtp_pkg::idle:
                begin
                    if (miss_valid)
                        state <= vtp_pkg::read;
                end
                vtp_pkg::read:
                begin
                    if (pt_rd_taken)
                        state <= vtp_pkg::wait_rsp;
                end
                vtp_pkg::wait_rsp:
                begin
                    if (pt_rsp_valid)
                        state <= vtp_pkg::fill;
                end
                default:
                begin
                    // An absent page is flagged and the walker goes back to idle
                    if (!pte_q.present)
                        pt_error <= 1'b1;
                    state <= vtp_pkg::idle;
                end
            endcase
        end
    end

    // The read request is a level held until the memory port takes it
    assign pt_rd_valid = (state == vtp_pkg::read);
    assign pt_rd_addr = pt_base + vtp_pkg::pa_line_t'(page_q);

    always_comb
    begin
        fill.en = (state == vtp_pkg::fill) && pte_q.present;
        fill.big_page = pte_q.big_page;
        fill.va_page = page_q;
        fill.pa_page = pte_q.pa_page;
        // Waiting replays are released even without a fill so they can walk again
        fill_done = (state == vtp_pkg::fill);
    end

endmodule

//--- logic/vtp_lookup_merge.sv
`timescale 1ns/1ps

// Merge stage that combines the TLB answers for one lookup
// Hits leave as translated reads and misses go to replay and to the walker

module vtp_lookup_merge
(
    input  logic                  clk,
    input  logic                  reset,
    input  vtp_pkg::tlb_lookup_t  lookup,
    input  vtp_pkg::tlb_answer_t  answer [vtp_pkg::page_sizes],
    output logic                  out_valid,
    output vtp_pkg::mem_req_t     out_req,
    output logic                  replay_valid,
    output vtp_pkg::mem_req_t     replay_req,
    output logic                  miss_valid,
    output vtp_pkg::va_page_4k_t  miss_page
);

    // The lookup delayed by one cycle lines up with the TLB answers
    vtp_pkg::tlb_lookup_t lk_q;

    vtp_pkg::va_line_t offset_mask;
    logic any_hit;
    logic all_miss;

    always_ff @(posedge clk)
    begin
        lk_q.req <= lookup.req;
        if (!reset)
            lk_q.valid <= 1'b0;
        else
            lk_q.valid <= lookup.valid;
    end

    always_comb
    begin
        out_req = lk_q.req;
        offset_mask = '0;
        any_hit = 1'b0;
        all_miss = 1'b1;

        // Only one page size can hold a given address
        for (int i = 0; i < vtp_pkg::page_sizes; i++)
        begin
            offset_mask = (vtp_pkg::va_line_t'(1) << vtp_pkg::page_line_bits[i]) - 1'b1;
            if (answer[i].hit)
            begin
                out_req.addr = answer[i].pa_base | (lk_q.req.addr & offset_mask);
            end
            any_hit = any_hit | answer[i].hit;
            all_miss = all_miss & answer[i].miss;
        end

        out_valid = lk_q.valid && any_hit;
        replay_valid = lk_q.valid && all_miss;
    end

    // The walker sees every miss and ignores those that come while it is busy
    assign replay_req = lk_q.req;
    assign miss_valid = replay_valid;
    assign miss_page = lk_q.req.addr[$bits(vtp_pkg::va_line_t)-1:vtp_pkg::page_line_bits[0]];

endmodule

//--- logic/vtp_tlb.sv
`timescale 1ns/1ps

// Direct-mapped TLB for one page size
// A lookup is answered one cycle later and a fill is written in its own cycle

module vtp_tlb
#(
    parameter int line_bits = 6,
    parameter int sets = 64
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  vtp_pkg::tlb_lookup_t  lookup,
    input  vtp_pkg::tlb_fill_t    fill,
    output vtp_pkg::tlb_answer_t  answer
);

    localparam int page_bits = $bits(vtp_pkg::va_line_t) - line_bits;
    localparam int idx_bits = $clog2(sets);
    localparam int tag_bits = page_bits - idx_bits;
    // Fills carry 4 KB page numbers, which are shifted down to this page size
    localparam int fill_shift = line_bits - vtp_pkg::page_line_bits[0];

    logic valid_mem [sets];
    logic [tag_bits-1:0] tag_mem [sets];
    logic [page_bits-1:0] pa_mem [sets];

    // Valid bits are cleared one set per cycle after reset
    logic init_done;
    logic [idx_bits-1:0] init_idx;

    logic [page_bits-1:0] lk_page;
    logic [page_bits-1:0] fill_va;
    logic [page_bits-1:0] fill_pa;

    logic lk_valid;
    logic rd_ok;
    logic [tag_bits-1:0] lk_tag;
    logic [tag_bits-1:0] rd_tag;
    logic [page_bits-1:0] rd_pa;

    assign lk_page = lookup.req.addr[$bits(vtp_pkg::va_line_t)-1:line_bits];
    assign fill_va = fill.va_page[$bits(vtp_pkg::va_page_4k_t)-1:fill_shift];
    assign fill_pa = fill.pa_page[$bits(vtp_pkg::pa_page_4k_t)-1:fill_shift];

    always_ff @(posedge clk)
    begin
        if (!init_done)
            valid_mem[init_idx] <= 1'b0;
        else if (fill.en)
            valid_mem[fill_va[idx_bits-1:0]] <= 1'b1;

        if (fill.en)
        begin
            tag_mem[fill_va[idx_bits-1:0]] <= fill_va[page_bits-1:idx_bits];
            pa_mem[fill_va[idx_bits-1:0]] <= fill_pa;
        end
    end

    always_ff @(posedge clk)
    begin
        lk_tag <= lk_page[page_bits-1:idx_bits];
        rd_tag <= tag_mem[lk_page[idx_bits-1:0]];
        rd_pa <= pa_mem[lk_page[idx_bits-1:0]];

        if (!reset)
        begin
            init_done <= 1'b0;
            init_idx <= '0;
            lk_valid <= 1'b0;
            rd_ok <= 1'b0;
        end
        else
        begin
            if (!init_done)
            begin
                init_idx <= init_idx + 1'b1;
                init_done <= (init_idx == idx_bits'(sets - 1));
            end
            lk_valid <= lookup.valid;
            // Until clearing ends every lookup is reported as a miss
            rd_ok <= init_done && valid_mem[lk_page[idx_bits-1:0]];
        end
    end

    always_comb
    begin
        answer.hit = lk_valid && rd_ok && (rd_tag == lk_tag);
        answer.miss = lk_valid && !answer.hit;
        answer.pa_base = {rd_pa, {line_bits{1'b0}}};
    end

endmodule

//--- logic/vtp_lookup_issue.sv
`timescale 1ns/1ps

// Issue stage of the translation pipeline
// Client reads queue in a skid FIFO and missed reads in a replay FIFO
// At most one lookup per cycle is broadcast to every TLB, replays first

module vtp_lookup_issue
#(
    parameter int skid_depth = 8,
    parameter int replay_depth = 4
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  afu_req_valid,
    input  vtp_pkg::mem_req_t     afu_req,
    input  logic                  mem_full,
    input  logic                  replay_valid,
    input  vtp_pkg::mem_req_t     replay_req,
    input  logic                  fill_done,
    output logic                  afu_almost_full,
    output vtp_pkg::tlb_lookup_t  lookup
);

    // Both depths are powers of two so the pointers wrap by themselves
    localparam int skid_pw = $clog2(skid_depth);
    localparam int skid_cw = $clog2(skid_depth + 1);
    localparam int replay_pw = $clog2(replay_depth);
    localparam int replay_cw = $clog2(replay_depth + 1);

    vtp_pkg::mem_req_t skid_mem [skid_depth];
    logic [skid_pw-1:0] skid_wr_ptr;
    logic [skid_pw-1:0] skid_rd_ptr;
    logic [skid_cw-1:0] skid_cnt;

    vtp_pkg::mem_req_t replay_mem [replay_depth];
    logic [replay_pw-1:0] replay_wr_ptr;
    logic [replay_pw-1:0] replay_rd_ptr;
    logic [replay_cw-1:0] replay_cnt;
    logic [replay_cw-1:0] replay_cnt_next;

    // Armed entries form a prefix of the FIFO since a fill arms everything stored so far
    logic [replay_cw-1:0] replay_armed;

    logic pop_replay;
    logic pop_skid;

    always_comb
    begin
        // A replay may only go once a fill could have made it hit
        pop_replay = !mem_full && (replay_armed != '0);

        // Two lookups ahead of a new read may still miss, so the replay FIFO
        // must have room for three more entries
        pop_skid = !mem_full && !pop_replay && (skid_cnt != '0) &&
                   (int'(replay_cnt) + 3 <= replay_depth);

        replay_cnt_next = replay_cnt + replay_cw'(replay_valid) - replay_cw'(pop_replay);
    end

    always_ff @(posedge clk)
    begin
        if (afu_req_valid)
        begin
            skid_mem[skid_wr_ptr] <= afu_req;
        end
        if (replay_valid)
        begin
            replay_mem[replay_wr_ptr] <= replay_req;
        end
        lookup.req <= pop_replay ? replay_mem[replay_rd_ptr] : skid_mem[skid_rd_ptr];

        if (!reset)
        begin
            skid_wr_ptr <= '0;
            skid_rd_ptr <= '0;
            skid_cnt <= '0;
            replay_wr_ptr <= '0;
            replay_rd_ptr <= '0;
            replay_cnt <= '0;
            replay_armed <= '0;
            lookup.valid <= 1'b0;
            afu_almost_full <= 1'b0;
        end
        else
        begin
            skid_wr_ptr <= skid_wr_ptr + skid_pw'(afu_req_valid);
            skid_rd_ptr <= skid_rd_ptr + skid_pw'(pop_skid);
            skid_cnt <= skid_cnt + skid_cw'(afu_req_valid) - skid_cw'(pop_skid);
            replay_wr_ptr <= replay_wr_ptr + replay_pw'(replay_valid);
            replay_rd_ptr <= replay_rd_ptr + replay_pw'(pop_replay);
            replay_cnt <= replay_cnt_next;

            // Entries written in the fill cycle are armed too, since their
            // lookup may have been turned away by a busy walker
            if (fill_done)
                replay_armed <= replay_cnt_next;
            else if (pop_replay)
                replay_armed <= replay_armed - 1'b1;

            lookup.valid <= pop_replay || pop_skid;

            // Four reads can still land after the condition holds. One comes in this
            // cycle and three follow the rise of the registered flag
            afu_almost_full <= mem_full || (replay_cnt != '0) ||
                               (int'(skid_cnt) >= skid_depth - 4);
        end
    end

endmodule

//--- logic/vtp_pkg.sv
// Shared types and constants of the virtual-to-physical translation shim
// Modules and the testbench refer to these by scoped name

package vtp_pkg;

    // ========================================
    // Addresses, tags and data
    // ========================================

    // Cache-line addresses of a 32-bit byte space with 64-byte lines
    typedef logic [25:0] va_line_t;
    typedef logic [25:0] pa_line_t;

    // Request tag. The top bit is reserved for page-table reads
    typedef logic [11:0] mdata_t;
    localparam int pt_tag_bit = 11;

    // 4 KB page numbers are the upper 20 bits of a line address
    typedef logic [19:0] va_page_4k_t;
    typedef logic [19:0] pa_page_4k_t;

    typedef logic [31:0] mem_data_t;

    // One TLB per page size. Index 0 holds 4 KB pages and index 1 holds 2 MB pages
    localparam int page_sizes = 2;
    localparam int page_line_bits [page_sizes] = '{6, 15};

    // ========================================
    // Structures
    // ========================================

    // For a big page the low 9 bits of pa_page are ignored
    typedef struct packed {
        logic        present;
        logic        big_page;
        logic [9:0]  reserved;
        pa_page_4k_t pa_page;
    } pte_t;

    // Carries a virtual line before translation and a physical line after it
    typedef struct packed {
        va_line_t addr;
        mdata_t   tag;
    } mem_req_t;

    typedef struct packed {
        mdata_t    tag;
        mem_data_t data;
    } mem_rsp_t;

    typedef struct packed {
        mem_req_t req;
        logic     valid;
    } tlb_lookup_t;

    // Physical line of the page base, offset bits zero
    typedef struct packed {
        logic     hit;
        logic     miss;
        pa_line_t pa_base;
    } tlb_answer_t;

    typedef struct packed {
        logic        en;
        logic        big_page;
        va_page_4k_t va_page;
        pa_page_4k_t pa_page;
    } tlb_fill_t;

    typedef enum logic [1:0] {idle, read, wait_rsp, fill} walk_state_t;

endpackage
